// File: Bender.yml
package:
  name: axi_rd_arbiter

sources:
  - files:
      - verilog/axi_rd_pkg.sv
      - verilog/rd_arb_pkg.sv
      - verilog/rd_master_arbiter.sv
      - verilog/rd_slave_router.sv
      - verilog/axi_rd_arbiter.sv
  - target: test
    files:
      - tests/rd_slave_model.sv
      - tests/tb_axi_rd_arbiter.sv

// File: build.f
verilog/axi_rd_pkg.sv
verilog/rd_arb_pkg.sv
verilog/rd_master_arbiter.sv
verilog/rd_slave_router.sv
verilog/axi_rd_arbiter.sv
tests/rd_slave_model.sv
tests/tb_axi_rd_arbiter.sv

// File: tests/rd_slave_model.sv
// ----------------------------------------------------------------------
// behavioral AXI read slave
// accepts a request after a random delay of one to three cycles and
// returns len+1 beats built from its own index, the address and the
// beat number
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module rd_slave_model #(
    parameter int SLV_IDX = 0
) (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  logic                s_arvalid,
    input  axi_rd_pkg::ar_req_t s_ar,
    output logic                s_arready,
    output logic                s_rvalid,
    output axi_rd_pkg::r_beat_t s_r,
    input  logic                s_rready
);

    axi_rd_pkg::ar_req_t req;
    int unsigned         dly;

    initial begin
        void'($urandom(57));
        s_arready = 1'b0;
        s_rvalid  = 1'b0;
        s_r       = '0;
        forever begin
            @(posedge ACLK);
            if (ARESETn && s_arvalid) begin
                dly = $urandom_range(3, 1);
                repeat (dly) @(negedge ACLK);
                s_arready = 1'b1;
                @(posedge ACLK);            // arvalid is held, handshake here
                req = s_ar;
                @(negedge ACLK);
                s_arready = 1'b0;
                for (int b = 0; b <= req.len; b++) begin
                    s_r.id   = req.id;
                    s_r.data = {8'(SLV_IDX), req.addr[15:0], 8'(b)};
                    s_r.resp = axi_rd_pkg::OKAY;
                    s_r.last = (b == req.len);
                    s_rvalid = 1'b1;
                    do @(posedge ACLK); while (!s_rready);   // hold under stall
                    @(negedge ACLK);
                end
                s_rvalid = 1'b0;
            end
        end
    end

endmodule

// File: tests/tb_axi_rd_arbiter.sv
// ----------------------------------------------------------------------
// testbench for the AXI read arbiter
// four masters driven by directed test tasks, eight behavioral slaves,
// a beat monitor, compare tasks, timeout and summary
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_axi_rd_arbiter;

    localparam int NUM_SLAVES     = 8;
    localparam int TEST_CYCLES    = 2000;   // ~20 bursts, up to 100 cycles each
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                    ACLK;
    logic                    ARESETn;
    logic [3:0]              m_arvalid;
    axi_rd_pkg::ar_req_t     m_ar [4];
    logic [3:0]              m_arready;
    logic [3:0]              m_rvalid;
    logic [3:0]              m_rready;
    axi_rd_pkg::r_beat_t     m_r;
    axi_rd_pkg::ar_req_t     s_ar;
    logic [NUM_SLAVES-1:0]   s_arvalid;
    wire  [NUM_SLAVES-1:0]   s_arready;
    wire  [NUM_SLAVES-1:0]   s_rvalid;
    wire axi_rd_pkg::r_beat_t s_r [NUM_SLAVES];
    logic [NUM_SLAVES-1:0]   s_rready;

    axi_rd_pkg::r_beat_t beat_q[$];        // accepted beats, in order
    logic [1:0]          beat_mst_q[$];    // receiving master per beat
    logic [1:0]          done_q[$];        // master per finished burst
    int                  beat_errs;
    int                  mst_errs;
    int                  other_errs;
    int                  cycle_cnt;

    axi_rd_arbiter #(.NUM_SLAVES(NUM_SLAVES)) axi_rd_arbiter_inst (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .m_arvalid(m_arvalid), .m_ar(m_ar), .m_arready(m_arready),
        .m_rvalid(m_rvalid), .m_rready(m_rready), .m_r(m_r),
        .s_ar(s_ar), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rvalid(s_rvalid), .s_r(s_r), .s_rready(s_rready)
    );

    for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_slave
        rd_slave_model #(.SLV_IDX(g)) u_slave (
            .ACLK(ACLK), .ARESETn(ARESETn),
            .s_arvalid(s_arvalid[g]), .s_ar(s_ar), .s_arready(s_arready[g]),
            .s_rvalid(s_rvalid[g]), .s_r(s_r[g]), .s_rready(s_rready[g])
        );
    end

    initial begin
        ACLK = 1'b0;
        forever #50 ACLK = ~ACLK;
    end

    // ------------------------------------------------------------------
    // monitor and watchdog
    // ------------------------------------------------------------------
    always @(posedge ACLK) begin
        for (int m = 0; m < 4; m++) begin
            if (ARESETn && m_rvalid[m] && m_rready[m]) begin
                beat_q.push_back(m_r);
                beat_mst_q.push_back(m[1:0]);
                if (m_r.last) done_q.push_back(m[1:0]);
            end
        end
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic axi_rd_pkg::ar_req_t make_req(input int id, input int slv,
                                                     input logic [15:0] offset, input int len);
        axi_rd_pkg::ar_req_t r;
        r.id   = id[axi_rd_pkg::ID_W-1:0];
        r.addr = {slv[2:0], 13'h0, offset};     // slave from the top three bits
        r.len  = len[axi_rd_pkg::LEN_W-1:0];
        return r;
    endfunction

    // slave byte, low address bits, beat number
    function automatic axi_rd_pkg::r_beat_t expected_beat(input int slv,
                                                          input axi_rd_pkg::ar_req_t req,
                                                          input int beat);
        axi_rd_pkg::r_beat_t b;
        b.id   = req.id;
        b.data = {slv[7:0], req.addr[15:0], beat[7:0]};
        b.resp = axi_rd_pkg::OKAY;
        b.last = (beat == req.len);
        return b;
    endfunction

    // first pending master at or above the pointer, with wraparound
    function automatic logic [1:0] next_served(input logic [1:0] ptr, input logic [3:0] pending);
        logic [1:0] cand;
        for (int k = 3; k >= 0; k--) begin
            cand = ptr + k[1:0];
            if (pending[cand]) next_served = cand;
        end
    endfunction

    task automatic compare_beat(input string name, input axi_rd_pkg::r_beat_t exp,
                                input axi_rd_pkg::r_beat_t act);
        if (act !== exp) begin
            beat_errs++;
            $display("error %s: expected beat %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_master(input string name, input logic [rd_arb_pkg::MST_IDX_W-1:0] exp,
                                  input logic [rd_arb_pkg::MST_IDX_W-1:0] act);
        if (act !== exp) begin
            mst_errs++;
            $display("error %s: expected master %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic clear_log();
        beat_q.delete();
        beat_mst_q.delete();
        done_q.delete();
    endtask

    task automatic reset_dut();
        @(negedge ACLK);
        ARESETn = 1'b0;
        repeat (10) @(negedge ACLK);
        ARESETn = 1'b1;
    endtask

    // hold arvalid until the address handshake
    task automatic send_ar(input int mst, input axi_rd_pkg::ar_req_t req);
        @(negedge ACLK);
        m_ar[mst]      = req;
        m_arvalid[mst] = 1'b1;
        do @(posedge ACLK); while (!m_arready[mst]);
        @(negedge ACLK);
        m_arvalid[mst] = 1'b0;
    endtask

    task automatic wait_bursts(input int n);
        while (done_q.size() < n) @(posedge ACLK);
    endtask

    task automatic check_burst(input string name, input int mst, input axi_rd_pkg::ar_req_t req);
        int slv;
        int got;
        slv = req.addr[31:29];
        got = 0;
        for (int i = 0; i < beat_q.size(); i++) begin
            if (beat_mst_q[i] == mst) begin
                compare_beat(name, expected_beat(slv, req, got), beat_q[i]);
                got++;
            end
        end
        if (got != req.len + 1) begin
            other_errs++;
            $display("error %s: expected %0d beats, actual %0d", name, req.len + 1, got);
        end
    endtask

    // completion order against the rotation rule
    task automatic check_order(input string name, input logic [3:0] pending_in,
                               inout logic [1:0] ptr);
        logic [3:0] pending;
        logic [1:0] exp_m;
        pending = pending_in;
        for (int n = 0; n < done_q.size(); n++) begin
            exp_m = next_served(ptr, pending);
            compare_master(name, exp_m, done_q[n]);
            pending[exp_m] = 1'b0;
            ptr = exp_m + 2'd1;
        end
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_round_robin();
        logic [1:0] ptr;
        ptr = 2'd0;                         // master 0 holds the grant after reset
        clear_log();
        fork
            send_ar(0, make_req(1, 0, 16'h0010, 0));
            send_ar(1, make_req(2, 1, 16'h0020, 0));
            send_ar(2, make_req(3, 2, 16'h0030, 0));
            send_ar(3, make_req(4, 3, 16'h0040, 0));
        join
        wait_bursts(4);
        check_order("round_robin_1", 4'b1111, ptr);
        clear_log();
        send_ar(2, make_req(5, 4, 16'h0050, 0));
        wait_bursts(1);
        check_order("round_robin_2", 4'b0100, ptr);
        clear_log();
        fork
            send_ar(0, make_req(6, 5, 16'h0060, 0));
            send_ar(1, make_req(7, 6, 16'h0070, 0));
            send_ar(2, make_req(8, 7, 16'h0080, 0));
            send_ar(3, make_req(9, 0, 16'h0090, 0));
        join
        wait_bursts(4);
        check_order("round_robin_3", 4'b1111, ptr);
    endtask

    task automatic test_routing();
        axi_rd_pkg::ar_req_t req;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            clear_log();
            req = make_req(s, s, 16'h0100 + 16'(s * 4), 0);
            send_ar(0, req);
            wait_bursts(1);
            check_burst("routing", 0, req);
        end
    endtask

    task automatic test_burst();
        axi_rd_pkg::ar_req_t req;
        clear_log();
        req = make_req(4'ha, 3, 16'h0200, 3);      // four beats
        send_ar(1, req);
        wait_bursts(1);
        check_burst("burst", 1, req);
    endtask

    task automatic test_backpressure();
        axi_rd_pkg::ar_req_t req;
        clear_log();
        req = make_req(4'hb, 5, 16'h0300, 5);
        fork
            send_ar(2, req);
            begin
                while (beat_q.size() < 2) @(negedge ACLK);
                m_rready[2] = 1'b0;                 // stall mid burst
                repeat (5) @(negedge ACLK);
                m_rready[2] = 1'b1;
            end
        join
        wait_bursts(1);
        check_burst("backpressure", 2, req);
    endtask

    task automatic test_isolation();
        axi_rd_pkg::ar_req_t req_a;
        axi_rd_pkg::ar_req_t req_b;
        clear_log();
        req_a = make_req(4'hc, 6, 16'h0400, 7);
        req_b = make_req(4'hd, 1, 16'h0500, 0);
        send_ar(3, req_a);
        fork
            send_ar(0, req_b);
            while (done_q.size() == 0) begin
                @(posedge ACLK);
                if (m_arready[0] || m_rvalid[0]) begin
                    other_errs++;
                    $display("isolation: master 0 saw a handshake during master 3's burst");
                end
            end
        join
        wait_bursts(2);
        compare_master("isolation_first", 2'd3, done_q[0]);
        compare_master("isolation_second", 2'd0, done_q[1]);
        check_burst("isolation", 3, req_a);
        check_burst("isolation", 0, req_b);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        ARESETn    = 1'b0;
        m_arvalid  = '0;
        m_rready   = '1;
        for (int m = 0; m < 4; m++) m_ar[m] = '0;
        beat_errs  = 0;
        mst_errs   = 0;
        other_errs = 0;
        cycle_cnt  = 0;
        reset_dut();
        test_round_robin();                 // must run straight after reset
        test_routing();
        test_burst();
        test_backpressure();
        test_isolation();
        repeat (5) @(negedge ACLK);
        $display("errors: beat %0d, master %0d, other %0d", beat_errs, mst_errs, other_errs);
        if (beat_errs + mst_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/axi_rd_arbiter.sv
// ----------------------------------------------------------------------
// AXI read arbiter, top level
// four masters share one read path to NUM_SLAVES slaves; a round-robin
// FSM picks the master and the router steers its burst to the slave
// chosen by the top address bits
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module axi_rd_arbiter #(
    parameter int NUM_SLAVES = 8        // 2 to 8
) (
    input  logic                               ACLK,
    input  logic                               ARESETn,

    // ------------------------------------------------------------------
    // master side
    // ------------------------------------------------------------------
    input  logic [rd_arb_pkg::NUM_MASTERS-1:0] m_arvalid,
    input  axi_rd_pkg::ar_req_t                m_ar [rd_arb_pkg::NUM_MASTERS],
    output logic [rd_arb_pkg::NUM_MASTERS-1:0] m_arready,
    output logic [rd_arb_pkg::NUM_MASTERS-1:0] m_rvalid,
    input  logic [rd_arb_pkg::NUM_MASTERS-1:0] m_rready,
    output axi_rd_pkg::r_beat_t                m_r,         // shared beat

    // ------------------------------------------------------------------
    // slave side
    // ------------------------------------------------------------------
    output axi_rd_pkg::ar_req_t                s_ar,        // shared request
    output logic [NUM_SLAVES-1:0]              s_arvalid,
    input  logic [NUM_SLAVES-1:0]              s_arready,
    input  logic [NUM_SLAVES-1:0]              s_rvalid,
    input  axi_rd_pkg::r_beat_t                s_r [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]              s_rready
);

    rd_arb_pkg::grant_t grant;
    logic               ar_hs;          // granted request accepted
    logic               r_last_hs;      // burst finished

    rd_master_arbiter u_arbiter (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .m_arvalid (m_arvalid),
        .ar_hs     (ar_hs),
        .r_last_hs (r_last_hs),
        .grant     (grant)
    );

    rd_slave_router #(
        .NUM_SLAVES (NUM_SLAVES)
    ) u_router (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .grant     (grant),
        .m_arvalid (m_arvalid),
        .m_ar      (m_ar),
        .m_rready  (m_rready),
        .s_arready (s_arready),
        .s_rvalid  (s_rvalid),
        .s_r       (s_r),
        .ar_hs     (ar_hs),
        .r_last_hs (r_last_hs),
        .m_arready (m_arready),
        .m_rvalid  (m_rvalid),
        .m_r       (m_r),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_rready  (s_rready)
    );

endmodule

// File: verilog/axi_rd_pkg.sv
// ----------------------------------------------------------------------
// AXI read channel definitions
// field widths, read response codes and the packed structs that carry
// the AR request and the R beat through the arbiter
// ----------------------------------------------------------------------

package axi_rd_pkg;

    // ------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------
    localparam int ADDR_W = 32;             // araddr
    localparam int DATA_W = 32;             // rdata
    localparam int ID_W   = 4;              // arid / rid
    localparam int LEN_W  = 8;              // arlen, beats minus one

    // ------------------------------------------------------------------
    // read response
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // ------------------------------------------------------------------
    // channel payloads, handshakes travel separately
    // ------------------------------------------------------------------

    // read address request, 44 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } ar_req_t;

    // read data beat, 39 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;        // final beat of the burst
    } r_beat_t;

endpackage

// File: verilog/rd_arb_pkg.sv
// ----------------------------------------------------------------------
// read arbiter definitions
// master count, grant phase and the grant word passed from the
// arbiter FSM to the slave router
// ----------------------------------------------------------------------

package rd_arb_pkg;

    localparam int NUM_MASTERS = 4;
    localparam int MST_IDX_W   = 2;         // log2 of NUM_MASTERS

    // ------------------------------------------------------------------
    // grant phase
    // ------------------------------------------------------------------
    typedef enum logic [0:0] {
        PH_ADDR = 1'b0,                     // waiting for the AR handshake
        PH_DATA = 1'b1                      // burst in flight
    } phase_e;

    // grant word, 3 bits
    typedef struct packed {
        logic [MST_IDX_W-1:0] mst;          // granted master
        phase_e               phase;
    } grant_t;

endpackage

// File: verilog/rd_master_arbiter.sv
// ----------------------------------------------------------------------
// read master arbiter
// round-robin grant over the four masters; the grant holds through the
// whole burst and moves on one past the owner after the last beat
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module rd_master_arbiter (
    input  logic                                  ACLK,
    input  logic                                  ARESETn,
    input  logic [rd_arb_pkg::NUM_MASTERS-1:0]    m_arvalid,
    input  logic                                  ar_hs,      // granted AR accepted
    input  logic                                  r_last_hs,  // last beat accepted
    output rd_arb_pkg::grant_t                    grant
);

    rd_arb_pkg::grant_t grant_q;
    rd_arb_pkg::grant_t grant_nxt;

    logic [rd_arb_pkg::MST_IDX_W-1:0] cand;     // candidate in the search
    logic [rd_arb_pkg::MST_IDX_W-1:0] rr_pick;  // first requester after owner
    logic                             rr_found;

    // ------------------------------------------------------------------
    // rotating priority search
    // ------------------------------------------------------------------
    // starts one above the current owner and wraps, so the owner itself
    // comes last
    always_comb begin
        rr_found = 1'b0;
        rr_pick  = grant_q.mst;
        cand     = grant_q.mst;
        for (int i = 1; i < rd_arb_pkg::NUM_MASTERS; i++) begin
            cand = grant_q.mst + i[rd_arb_pkg::MST_IDX_W-1:0];  // wraps mod 4
            if (!rr_found && m_arvalid[cand]) begin
                rr_found = 1'b1;
                rr_pick  = cand;
            end
        end
    end

    // ------------------------------------------------------------------
    // grant FSM
    // ------------------------------------------------------------------
    always_comb begin
        grant_nxt = grant_q;
        case (grant_q.phase)
            rd_arb_pkg::PH_ADDR: begin
                if (m_arvalid[grant_q.mst]) begin
                    // owner keeps the grant while it requests
                    if (ar_hs) begin
                        grant_nxt.phase = rd_arb_pkg::PH_DATA;
                    end
                end else if (rr_found) begin
                    grant_nxt.mst = rr_pick;            // idle owner, hand over
                end
            end
            rd_arb_pkg::PH_DATA: begin
                if (r_last_hs) begin
                    grant_nxt.mst   = grant_q.mst + 1'b1;   // next in rotation
                    grant_nxt.phase = rd_arb_pkg::PH_ADDR;
                end
            end
            default: begin
                grant_nxt.phase = rd_arb_pkg::PH_ADDR;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            grant_q.mst   <= '0;                    // master 0 first
            grant_q.phase <= rd_arb_pkg::PH_ADDR;
        end else begin
            grant_q <= grant_nxt;
        end
    end

    assign grant = grant_q;

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    // a burst is only closed by the router's last-beat handshake
    a_data_until_last : assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (grant_q.phase == rd_arb_pkg::PH_DATA && !r_last_hs)
            |=> (grant_q.phase == rd_arb_pkg::PH_DATA)
    );

    // owner is frozen while its burst runs
    a_mst_stable_in_data : assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (grant_q.phase == rd_arb_pkg::PH_DATA && !r_last_hs)
            |=> $stable(grant_q.mst)
    );

endmodule

// File: verilog/rd_slave_router.sv
// ----------------------------------------------------------------------
// read slave router
// decodes the target slave from the top address bits, steers the AR and
// R handshakes between the granted master and that slave, and
// broadcasts the selected slave's beat to all masters
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module rd_slave_router #(
    parameter int NUM_SLAVES = 8
) (
    input  logic                               ACLK,
    input  logic                               ARESETn,
    input  rd_arb_pkg::grant_t                 grant,
    input  logic [rd_arb_pkg::NUM_MASTERS-1:0] m_arvalid,
    input  axi_rd_pkg::ar_req_t                m_ar [rd_arb_pkg::NUM_MASTERS],
    input  logic [rd_arb_pkg::NUM_MASTERS-1:0] m_rready,
    input  logic [NUM_SLAVES-1:0]              s_arready,
    input  logic [NUM_SLAVES-1:0]              s_rvalid,
    input  axi_rd_pkg::r_beat_t                s_r [NUM_SLAVES],
    output logic                               ar_hs,
    output logic                               r_last_hs,
    output logic [rd_arb_pkg::NUM_MASTERS-1:0] m_arready,
    output logic [rd_arb_pkg::NUM_MASTERS-1:0] m_rvalid,
    output axi_rd_pkg::r_beat_t                m_r,
    output axi_rd_pkg::ar_req_t                s_ar,
    output logic [NUM_SLAVES-1:0]              s_arvalid,
    output logic [NUM_SLAVES-1:0]              s_rready
);

    localparam int SEL_W = $clog2(NUM_SLAVES);

    logic [SEL_W-1:0] ar_sel;       // decoded from the live request
    logic             ar_sel_ok;    // region maps to a real slave
    logic [SEL_W-1:0] sel_q;        // slave owning the burst
    logic             addr_ph;
    logic             data_ph;
    logic             arvalid_g;
    logic             arready_g;
    logic             rvalid_g;
    logic             rready_g;

    assign addr_ph = (grant.phase == rd_arb_pkg::PH_ADDR);
    assign data_ph = (grant.phase == rd_arb_pkg::PH_DATA);

    // ------------------------------------------------------------------
    // address path
    // ------------------------------------------------------------------
    assign s_ar      = m_ar[grant.mst];                         // shared AR payload
    assign ar_sel    = s_ar.addr[axi_rd_pkg::ADDR_W-1 -: SEL_W];
    assign ar_sel_ok = (ar_sel < NUM_SLAVES);
    assign arvalid_g = addr_ph && m_arvalid[grant.mst] && ar_sel_ok;
    assign arready_g = addr_ph && ar_sel_ok && s_arready[ar_sel];
    assign ar_hs     = arvalid_g && arready_g;

    always_comb begin
        s_arvalid = '0;
        m_arready = '0;
        if (ar_sel_ok) begin
            s_arvalid[ar_sel] = arvalid_g;
        end
        m_arready[grant.mst] = arready_g;
    end

    // slave index captured at the AR handshake, held for the burst
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            sel_q <= '0;
        end else if (ar_hs) begin
            sel_q <= ar_sel;
        end
    end

    // ------------------------------------------------------------------
    // data path
    // ------------------------------------------------------------------
    assign m_r       = s_r[sel_q];                              // seen by every master
    assign rvalid_g  = data_ph && s_rvalid[sel_q];
    assign rready_g  = data_ph && m_rready[grant.mst];
    assign r_last_hs = rvalid_g && rready_g && m_r.last;

    always_comb begin
        m_rvalid = '0;
        s_rready = '0;
        m_rvalid[grant.mst] = rvalid_g;
        s_rready[sel_q]     = rready_g;   // master back-pressure reaches the slave
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    a_one_arvalid : assert property (
        @(posedge ACLK) disable iff (!ARESETn) $onehot0(s_arvalid)
    );

    a_one_rvalid : assert property (
        @(posedge ACLK) disable iff (!ARESETn) $onehot0(m_rvalid)
    );

endmodule
